// ==== src/scr1_mem_pkg.sv ====
//------------------------------------------------
// Shared types and address map for the data-side
// memory subsystem. Modules import it in their body
//------------------------------------------------

package scr1_mem_pkg;

    parameter int XLEN = 32;

    //------------------------------------------------
    // Address map
    //------------------------------------------------
    parameter logic [XLEN-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;  // 32-byte window
    parameter logic [XLEN-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000;
    parameter logic [XLEN-1:0] TCM_ADDR_MASK      = 32'hFFFF_F000;  // 4 KiB default
    parameter logic [XLEN-1:0] TCM_ADDR_PATTERN   = 32'h0000_0000;

    // Timer register offsets inside its window
    parameter logic [4:0] TIMER_CTRL_OFS      = 5'h00;
    parameter logic [4:0] TIMER_DIV_OFS       = 5'h04;
    parameter logic [4:0] TIMER_MTIME_OFS     = 5'h08;
    parameter logic [4:0] TIMER_MTIMEH_OFS    = 5'h0C;
    parameter logic [4:0] TIMER_MTIMECMP_OFS  = 5'h10;
    parameter logic [4:0] TIMER_MTIMECMPH_OFS = 5'h14;

    //------------------------------------------------
    // Access types
    //------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,    // Idle, no response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    typedef struct packed {
        mem_cmd_e           cmd;
        mem_width_e         width;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } mem_req_t;

    typedef struct packed {
        mem_resp_e          resp;
        logic [XLEN-1:0]    rdata;
    } mem_rsp_t;

endpackage : scr1_mem_pkg

// ==== src/scr1_dmem_router.sv ====
//------------------------------------------------
// Data-side address router. Steers each host access
// to AHB (port 0), TCM (port 1) or timer (port 2)
//------------------------------------------------
`timescale 1ns/100ps

module scr1_dmem_router #(
    parameter logic [31:0] PORT1_ADDR_MASK    = 32'hFFFF_F000,
    parameter logic [31:0] PORT1_ADDR_PATTERN = 32'h0000_0000,
    parameter logic [31:0] PORT2_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter logic [31:0] PORT2_ADDR_PATTERN = 32'h0049_0000
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    // Host side
    input  logic                    i_req,
    input  scr1_mem_pkg::mem_req_t  i_cmd,
    output logic                    o_req_ack,
    output scr1_mem_pkg::mem_rsp_t  o_rsp,
    // Port 0 to the AHB bridge
    output logic                    o_port0_req,
    output scr1_mem_pkg::mem_req_t  o_port0_cmd,
    input  logic                    i_port0_req_ack,
    input  scr1_mem_pkg::mem_rsp_t  i_port0_rsp,
    // Port 1 to the TCM
    output logic                    o_port1_req,
    output scr1_mem_pkg::mem_req_t  o_port1_cmd,
    input  logic                    i_port1_req_ack,
    input  scr1_mem_pkg::mem_rsp_t  i_port1_rsp,
    // Port 2 to the timer
    output logic                    o_port2_req,
    output scr1_mem_pkg::mem_req_t  o_port2_cmd,
    input  logic                    i_port2_req_ack,
    input  scr1_mem_pkg::mem_rsp_t  i_port2_rsp
);

    import scr1_mem_pkg::*;

    typedef enum logic [1:0] {
        PORT_AHB   = 2'd0,
        PORT_TCM   = 2'd1,
        PORT_TIMER = 2'd2
    } port_e;

    port_e      sel;
    port_e      owner;          // Port of the outstanding access
    logic       busy;
    logic       sel_ack;
    logic       rsp_done;
    logic       req_allowed;
    mem_rsp_t   own_rsp;
    logic [2:0] rsp_vld;
    logic [2:0] own_mask;

    // Window decode, AHB when nothing matches
    always_comb begin
        if ((i_cmd.addr & PORT1_ADDR_MASK) == PORT1_ADDR_PATTERN) begin
            sel = PORT_TCM;
        end else if ((i_cmd.addr & PORT2_ADDR_MASK) == PORT2_ADDR_PATTERN) begin
            sel = PORT_TIMER;
        end else begin
            sel = PORT_AHB;
        end
    end

    always_comb begin
        case (owner)
            PORT_TCM:   own_rsp = i_port1_rsp;
            PORT_TIMER: own_rsp = i_port2_rsp;
            default:    own_rsp = i_port0_rsp;
        endcase
        case (sel)
            PORT_TCM:   sel_ack = i_port1_req_ack;
            PORT_TIMER: sel_ack = i_port2_req_ack;
            default:    sel_ack = i_port0_req_ack;
        endcase
    end

    assign rsp_done    = busy & (own_rsp.resp != MEM_RESP_NOTRDY);
    assign req_allowed = ~busy | rsp_done;  // New access may overlap the last response

    assign o_port0_req = i_req & req_allowed & (sel == PORT_AHB);
    assign o_port1_req = i_req & req_allowed & (sel == PORT_TCM);
    assign o_port2_req = i_req & req_allowed & (sel == PORT_TIMER);
    assign o_port0_cmd = i_cmd;
    assign o_port1_cmd = i_cmd;
    assign o_port2_cmd = i_cmd;

    assign o_req_ack   = i_req & req_allowed & sel_ack;
    assign o_rsp.resp  = busy ? own_rsp.resp : MEM_RESP_NOTRDY;
    assign o_rsp.rdata = own_rsp.rdata;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy  <= 1'b0;
            owner <= PORT_AHB;
        end else if (o_req_ack) begin
            busy  <= 1'b1;
            owner <= sel;
        end else if (rsp_done) begin
            busy  <= 1'b0;
        end
    end

    //------------------------------------------------
    // Checks
    //------------------------------------------------
    assign rsp_vld  = {i_port2_rsp.resp != MEM_RESP_NOTRDY,
                       i_port1_rsp.resp != MEM_RESP_NOTRDY,
                       i_port0_rsp.resp != MEM_RESP_NOTRDY};
    assign own_mask = busy ? (3'b001 << owner) : 3'b000;

    // Targets acknowledge only a request routed to them
    a_ack_routed: assert property (@(posedge i_clk) disable iff (i_reset)
        ({i_port2_req_ack, i_port1_req_ack, i_port0_req_ack}
            & ~{o_port2_req, o_port1_req, o_port0_req}) == 3'b000);

    // Targets answer only for the access they were given
    a_rsp_owner: assert property (@(posedge i_clk) disable iff (i_reset)
        (rsp_vld & ~own_mask) == 3'b000);

endmodule : scr1_dmem_router

// ==== src/scr1_tcm.sv ====
//------------------------------------------------
// Tightly coupled data memory. Accepts every request
// at once and answers on the next clock edge
//------------------------------------------------
`timescale 1ns/100ps

module scr1_tcm #(
    parameter int TCM_AWIDTH = 12   // Byte address bits
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_req,
    input  scr1_mem_pkg::mem_req_t  i_cmd,
    output logic                    o_req_ack,
    output scr1_mem_pkg::mem_rsp_t  o_rsp
);

    import scr1_mem_pkg::*;

    localparam int DEPTH = 2 ** (TCM_AWIDTH - 2);

    logic [XLEN-1:0]        mem [DEPTH];
    logic [TCM_AWIDTH-3:0]  widx;
    logic [3:0]             be;
    logic                   misaligned;
    mem_resp_e              resp_q;
    logic [XLEN-1:0]        rdata_q;

    assign o_req_ack = i_req;
    assign widx      = i_cmd.addr[TCM_AWIDTH-1:2];

    // Byte enables from width and low address bits
    always_comb begin
        be         = 4'b1111;
        misaligned = 1'b0;
        case (i_cmd.width)
            MEM_WIDTH_BYTE: begin
                be = 4'b0001 << i_cmd.addr[1:0];
            end
            MEM_WIDTH_HWORD: begin
                be         = i_cmd.addr[1] ? 4'b1100 : 4'b0011;
                misaligned = i_cmd.addr[0];
            end
            default: begin
                misaligned = |i_cmd.addr[1:0];
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_req && i_cmd.cmd == MEM_CMD_WR && !misaligned) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) mem[widx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];  // Same lane
            end
        end
        if (i_req) rdata_q <= mem[widx];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            resp_q <= MEM_RESP_NOTRDY;
        end else if (i_req) begin
            resp_q <= misaligned ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        end else begin
            resp_q <= MEM_RESP_NOTRDY;
        end
    end

    assign o_rsp.resp  = resp_q;
    assign o_rsp.rdata = rdata_q;

endmodule : scr1_tcm

// ==== src/scr1_timer.sv ====
//------------------------------------------------
// Memory-mapped machine timer. mtime counts divided
// clock cycles and raises the irq against mtimecmp
//------------------------------------------------
`timescale 1ns/100ps

module scr1_timer (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_req,
    input  scr1_mem_pkg::mem_req_t  i_cmd,
    output logic                    o_req_ack,
    output scr1_mem_pkg::mem_rsp_t  o_rsp,
    output logic [63:0]             o_mtime,
    output logic                    o_timer_irq
);

    import scr1_mem_pkg::*;

    logic               ctrl_en;
    logic [9:0]         div;
    logic [9:0]         div_cnt;
    logic [63:0]        mtime;
    logic [63:0]        mtimecmp;
    logic               irq_q;
    logic               tick;
    logic [4:0]         ofs;
    logic               ofs_ok;
    logic               acc_err;
    logic               wr_en;
    logic [XLEN-1:0]    rdata_nxt;
    logic [XLEN-1:0]    rdata_q;
    mem_resp_e          resp_q;

    assign o_req_ack = i_req;
    assign ofs       = i_cmd.addr[4:0];
    assign tick      = ctrl_en & (div_cnt == div);  // One step per DIV+1 cycles

    // Register read mux and offset decode
    always_comb begin
        ofs_ok    = 1'b1;
        rdata_nxt = '0;
        case (ofs)
            TIMER_CTRL_OFS:      rdata_nxt = {31'b0, ctrl_en};
            TIMER_DIV_OFS:       rdata_nxt = {22'b0, div};
            TIMER_MTIME_OFS:     rdata_nxt = mtime[31:0];
            TIMER_MTIMEH_OFS:    rdata_nxt = mtime[63:32];
            TIMER_MTIMECMP_OFS:  rdata_nxt = mtimecmp[31:0];
            TIMER_MTIMECMPH_OFS: rdata_nxt = mtimecmp[63:32];
            default:             ofs_ok    = 1'b0;
        endcase
    end

    assign acc_err = (i_cmd.width != MEM_WIDTH_WORD) | ~ofs_ok;
    assign wr_en   = i_req & (i_cmd.cmd == MEM_CMD_WR) & ~acc_err;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ctrl_en  <= 1'b1;
            div      <= '0;
            div_cnt  <= '0;
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (ctrl_en) div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)    mtime   <= mtime + 64'd1;
            // Register writes win over the count
            if (wr_en) begin
                case (ofs)
                    TIMER_CTRL_OFS: ctrl_en <= i_cmd.wdata[0];
                    TIMER_DIV_OFS: begin
                        div     <= i_cmd.wdata[9:0];
                        div_cnt <= '0;
                    end
                    TIMER_MTIME_OFS:     mtime[31:0]     <= i_cmd.wdata;
                    TIMER_MTIMEH_OFS:    mtime[63:32]    <= i_cmd.wdata;
                    TIMER_MTIMECMP_OFS:  mtimecmp[31:0]  <= i_cmd.wdata;
                    TIMER_MTIMECMPH_OFS: mtimecmp[63:32] <= i_cmd.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            irq_q  <= 1'b0;
            resp_q <= MEM_RESP_NOTRDY;
        end else begin
            irq_q  <= (mtime >= mtimecmp);
            if (i_req) resp_q <= acc_err ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            else       resp_q <= MEM_RESP_NOTRDY;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req) rdata_q <= rdata_nxt;
    end

    assign o_rsp.resp  = resp_q;
    assign o_rsp.rdata = rdata_q;
    assign o_mtime     = mtime;
    assign o_timer_irq = irq_q;

endmodule : scr1_timer

// ==== src/scr1_dmem_ahb.sv ====
//------------------------------------------------
// Bridge from processor accesses to single AHB-Lite
// transfers. Answers one cycle after the data phase
//------------------------------------------------
`timescale 1ns/100ps

module scr1_dmem_ahb (
    input  logic                    i_clk,
    input  logic                    i_reset,
    // Router side
    input  logic                    i_req,
    input  scr1_mem_pkg::mem_req_t  i_cmd,
    output logic                    o_req_ack,
    output scr1_mem_pkg::mem_rsp_t  o_rsp,
    // AHB-Lite master
    output logic [1:0]              o_htrans,
    output logic [2:0]              o_hsize,
    output logic [31:0]             o_haddr,
    output logic                    o_hwrite,
    output logic [31:0]             o_hwdata,
    input  logic                    i_hready,
    input  logic [31:0]             i_hrdata,
    input  logic                    i_hresp
);

    import scr1_mem_pkg::*;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_DATA = 2'd1,
        ST_RESP = 2'd2
    } state_e;

    state_e             state;
    logic               addr_phase;
    mem_cmd_e           cmd_q;
    logic [XLEN-1:0]    wdata_q;
    logic [XLEN-1:0]    rdata_q;
    logic               err_q;

    // No transfer in the data phase, so the bus is free for a new address
    assign addr_phase = (state != ST_DATA);
    assign o_req_ack  = i_req & addr_phase & i_hready;

    assign o_htrans = (i_req && addr_phase) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign o_haddr  = i_cmd.addr;
    assign o_hsize  = {1'b0, i_cmd.width};   // Byte, halfword, word map straight
    assign o_hwrite = i_req & addr_phase & (i_cmd.cmd == MEM_CMD_WR);
    assign o_hwdata = wdata_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_DATA: if (i_hready) state <= ST_RESP;
                default: state <= o_req_ack ? ST_DATA : ST_IDLE;
            endcase
        end
    end

    // Data phase payload
    always_ff @(posedge i_clk) begin
        if (o_req_ack) begin
            cmd_q   <= i_cmd.cmd;
            wdata_q <= i_cmd.wdata;
        end
        if (state == ST_DATA && i_hready) begin
            rdata_q <= (cmd_q == MEM_CMD_RD) ? i_hrdata : '0;
            err_q   <= i_hresp;
        end
    end

    always_comb begin
        o_rsp.rdata = rdata_q;
        if (state != ST_RESP) begin
            o_rsp.resp = MEM_RESP_NOTRDY;
        end else begin
            o_rsp.resp = err_q ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        end
    end

    // Requester must hold the access through an extended address phase
    a_addr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_htrans == HTRANS_NONSEQ && !i_hready)
            |=> (o_htrans == HTRANS_NONSEQ && $stable(o_haddr)));

endmodule : scr1_dmem_ahb

// ==== src/scr1_dmem_subsys_top.sv ====
//------------------------------------------------
// Data memory subsystem top. Host port feeds the
// router, which serves TCM, timer and AHB bridge
//------------------------------------------------
`timescale 1ns/100ps

module scr1_dmem_subsys_top #(
    parameter logic [31:0] TCM_ADDR_MASK    = scr1_mem_pkg::TCM_ADDR_MASK,
    parameter logic [31:0] TCM_ADDR_PATTERN = scr1_mem_pkg::TCM_ADDR_PATTERN
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    // Host data port
    input  logic                    i_dmem_req,
    input  scr1_mem_pkg::mem_req_t  i_dmem_cmd,
    output logic                    o_dmem_req_ack,
    output scr1_mem_pkg::mem_rsp_t  o_dmem_rsp,
    // Timer
    output logic                    o_timer_irq,
    output logic [63:0]             o_mtime,
    // External AHB-Lite
    output logic [1:0]              o_htrans,
    output logic [2:0]              o_hsize,
    output logic [31:0]             o_haddr,
    output logic                    o_hwrite,
    output logic [31:0]             o_hwdata,
    input  logic                    i_hready,
    input  logic [31:0]             i_hrdata,
    input  logic                    i_hresp
);

    import scr1_mem_pkg::*;

    localparam logic [XLEN-1:0] TCM_SIZE   = ~TCM_ADDR_MASK + 1'b1;
    localparam int              TCM_AWIDTH = $clog2(TCM_SIZE);

    //------------------------------------------------
    // Router to target wires
    //------------------------------------------------
    logic       ahb_req, tcm_req, timer_req;
    logic       ahb_req_ack, tcm_req_ack, timer_req_ack;
    mem_req_t   ahb_cmd, tcm_cmd, timer_cmd;
    mem_rsp_t   ahb_rsp, tcm_rsp, timer_rsp;

    scr1_dmem_router #(
        .PORT1_ADDR_MASK    (TCM_ADDR_MASK),
        .PORT1_ADDR_PATTERN (TCM_ADDR_PATTERN),
        .PORT2_ADDR_MASK    (TIMER_ADDR_MASK),
        .PORT2_ADDR_PATTERN (TIMER_ADDR_PATTERN)
    ) i_router (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_req              (i_dmem_req),
        .i_cmd              (i_dmem_cmd),
        .o_req_ack          (o_dmem_req_ack),
        .o_rsp              (o_dmem_rsp),
        .o_port0_req        (ahb_req),
        .o_port0_cmd        (ahb_cmd),
        .i_port0_req_ack    (ahb_req_ack),
        .i_port0_rsp        (ahb_rsp),
        .o_port1_req        (tcm_req),
        .o_port1_cmd        (tcm_cmd),
        .i_port1_req_ack    (tcm_req_ack),
        .i_port1_rsp        (tcm_rsp),
        .o_port2_req        (timer_req),
        .o_port2_cmd        (timer_cmd),
        .i_port2_req_ack    (timer_req_ack),
        .i_port2_rsp        (timer_rsp)
    );

    scr1_tcm #(
        .TCM_AWIDTH (TCM_AWIDTH)
    ) i_tcm (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (tcm_req),
        .i_cmd      (tcm_cmd),
        .o_req_ack  (tcm_req_ack),
        .o_rsp      (tcm_rsp)
    );

    scr1_timer i_timer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_req          (timer_req),
        .i_cmd          (timer_cmd),
        .o_req_ack      (timer_req_ack),
        .o_rsp          (timer_rsp),
        .o_mtime        (o_mtime),
        .o_timer_irq    (o_timer_irq)
    );

    scr1_dmem_ahb i_dmem_ahb (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (ahb_req),
        .i_cmd      (ahb_cmd),
        .o_req_ack  (ahb_req_ack),
        .o_rsp      (ahb_rsp),
        .o_htrans   (o_htrans),
        .o_hsize    (o_hsize),
        .o_haddr    (o_haddr),
        .o_hwrite   (o_hwrite),
        .o_hwdata   (o_hwdata),
        .i_hready   (i_hready),
        .i_hrdata   (i_hrdata),
        .i_hresp    (i_hresp)
    );

endmodule : scr1_dmem_subsys_top

// ==== test/tb_tasks.svh ====
//------------------------------------------------
// Host access, check and wait tasks and the directed
// tests. Included in the body of the testbench top
//------------------------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

    // Expected contents of each target
    logic [31:0]    tcm_exp [1024];
    logic [31:0]    ahb_exp [256];
    logic [31:0]    cmp_exp [2];
    integer         stim_seed = 32'h1eb2_ad1a;

    // Initial AHB memory word built from the full byte address
    function automatic logic [31:0] ahb_fill(input logic [7:0] idx);
        logic [31:0] a;
        a = AHB_BASE | {22'b0, idx, 2'b00};
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] timer_addr(input logic [4:0] ofs);
        return TIMER_ADDR_PATTERN | {27'b0, ofs};
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error: time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // One host access with the request held until req_ack
    task automatic do_access(input mem_cmd_e acc_cmd, input mem_width_e acc_width,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             output mem_resp_e resp, output logic [31:0] rdata);
        mem_req_t   req_v;
        int         cycles;
        req_v.cmd   = acc_cmd;
        req_v.width = acc_width;
        req_v.addr  = addr;
        req_v.wdata = wdata;
        dmem_req <= 1'b1;
        dmem_cmd <= req_v;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out waiting for req_ack, address %h", addr);
                abort_run();
            end
        end while (dmem_req_ack !== 1'b1);
        dmem_req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out waiting for the response, address %h", addr);
                abort_run();
            end
        end while (dmem_rsp.resp === MEM_RESP_NOTRDY);
        resp  = dmem_rsp.resp;
        rdata = dmem_rsp.rdata;
    endtask

    task automatic write_expect(input mem_width_e width, input logic [31:0] addr,
                                input logic [31:0] wdata, input mem_resp_e exp_resp);
        mem_resp_e      resp;
        logic [31:0]    rdata;
        do_access(MEM_CMD_WR, width, addr, wdata, resp, rdata);
        check(resp, exp_resp, $sformatf("write response at %h", addr));
    endtask

    task automatic read_expect(input mem_width_e width, input logic [31:0] addr,
                               input mem_resp_e exp_resp, input logic [31:0] exp_data);
        mem_resp_e      resp;
        logic [31:0]    rdata;
        do_access(MEM_CMD_RD, width, addr, '0, resp, rdata);
        check(resp, exp_resp, $sformatf("read response at %h", addr));
        if (exp_resp == MEM_RESP_RDY_OK) check(rdata, exp_data, $sformatf("read data at %h", addr));
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        mem_resp_e resp;
        do_access(MEM_CMD_RD, MEM_WIDTH_WORD, addr, '0, resp, data);
        check(resp, MEM_RESP_RDY_OK, $sformatf("read response at %h", addr));
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (timer_irq !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out waiting for the timer interrupt to go to %b", level);
                abort_run();
            end
        end
    endtask

    //------------------------------------------------
    // Directed tests
    //------------------------------------------------
    task automatic test_reset_state();
        check(dmem_req_ack, 1'b0, "req_ack after reset");
        check(timer_irq, 1'b0, "timer irq after reset");
        check(hwrite, 1'b0, "hwrite after reset");
        check(htrans, 2'b00, "htrans after reset");
        check(dmem_rsp.resp, MEM_RESP_NOTRDY, "response after reset");
    endtask

    task automatic test_tcm_lanes();
        write_expect(MEM_WIDTH_WORD, 32'h100, 32'h1122_3344, MEM_RESP_RDY_OK);
        write_expect(MEM_WIDTH_BYTE, 32'h101, 32'h0000_AB00, MEM_RESP_RDY_OK);   // Lane 1
        write_expect(MEM_WIDTH_HWORD, 32'h102, 32'hCDEF_0000, MEM_RESP_RDY_OK);  // Upper half
        read_expect(MEM_WIDTH_WORD, 32'h100, MEM_RESP_RDY_OK, 32'hCDEF_AB44);
        // Misaligned accesses must leave the word alone
        write_expect(MEM_WIDTH_WORD, 32'h102, 32'hFFFF_FFFF, MEM_RESP_RDY_ER);
        write_expect(MEM_WIDTH_HWORD, 32'h101, 32'hFFFF_FFFF, MEM_RESP_RDY_ER);
        read_expect(MEM_WIDTH_WORD, 32'h106, MEM_RESP_RDY_ER, '0);
        read_expect(MEM_WIDTH_WORD, 32'h100, MEM_RESP_RDY_OK, 32'hCDEF_AB44);
    endtask

    task automatic test_ahb_path();
        logic [31:0]    addrs [8];
        logic [31:0]    data;
        logic [7:0]     idx;
        for (int i = 0; i < 8; i++) begin
            idx      = 8'($random(stim_seed));
            data     = $random(stim_seed);
            addrs[i] = AHB_BASE | {22'b0, idx, 2'b00};
            write_expect(MEM_WIDTH_WORD, addrs[i], data, MEM_RESP_RDY_OK);
            ahb_exp[idx] = data;
            check(ahb_mem[idx], data, "AHB slave memory after write");
        end
        for (int i = 0; i < 8; i++) begin
            read_expect(MEM_WIDTH_WORD, addrs[i], MEM_RESP_RDY_OK, ahb_exp[addrs[i][9:2]]);
        end
        read_expect(MEM_WIDTH_WORD, AHB_BASE | 32'h3FC, MEM_RESP_RDY_OK, ahb_exp[255]);
        read_expect(MEM_WIDTH_WORD, 32'hF000_0010, MEM_RESP_RDY_ER, '0);
        write_expect(MEM_WIDTH_WORD, 32'hFFFF_FF00, 32'h1234_5678, MEM_RESP_RDY_ER);
    endtask

    task automatic test_timer_count();
        logic [31:0] t0;
        logic [31:0] t1;
        read_expect(MEM_WIDTH_WORD, timer_addr(TIMER_CTRL_OFS), MEM_RESP_RDY_OK, 32'd1);
        read_expect(MEM_WIDTH_WORD, timer_addr(TIMER_DIV_OFS), MEM_RESP_RDY_OK, 32'd0);
        read_word(timer_addr(TIMER_MTIME_OFS), t0);
        repeat (20) @(posedge clk);
        read_word(timer_addr(TIMER_MTIME_OFS), t1);
        check(t1 > t0, 1'b1, "mtime strictly increasing");
        check((t1 - t0) >= 32'd20, 1'b1, "mtime steps every cycle with DIV 0");
        check(mtime >= {32'b0, t0}, 1'b1, "o_mtime below the earlier register read");
    endtask

    task automatic test_timer_irq();
        // High half first so the compare never passes through a small value early
        write_expect(MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMPH_OFS), '0, MEM_RESP_RDY_OK);
        write_expect(MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_OFS), 32'h40, MEM_RESP_RDY_OK);
        wait_irq(1'b1);
        write_expect(MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_OFS), '1, MEM_RESP_RDY_OK);
        write_expect(MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMPH_OFS), '1, MEM_RESP_RDY_OK);
        wait_irq(1'b0);
        read_expect(MEM_WIDTH_WORD, timer_addr(TIMER_MTIMECMP_OFS), MEM_RESP_RDY_OK, '1);
        read_expect(MEM_WIDTH_BYTE, timer_addr(TIMER_MTIME_OFS), MEM_RESP_RDY_ER, '0);
        write_expect(MEM_WIDTH_BYTE, timer_addr(TIMER_CTRL_OFS), '0, MEM_RESP_RDY_ER);
        read_expect(MEM_WIDTH_WORD, timer_addr(5'h18), MEM_RESP_RDY_ER, '0);   // No register
    endtask

    task automatic test_mixed_traffic();
        logic [31:0]    addrs [9];
        logic [31:0]    data;
        logic [31:0]    pick;
        logic [31:0]    expd;
        for (int i = 0; i < 9; i++) begin
            data = $random(stim_seed);
            pick = $random(stim_seed);
            case (i % 3)
                0: begin
                    addrs[i] = TCM_ADDR_PATTERN | {20'b0, pick[11:2], 2'b00};
                    tcm_exp[pick[11:2]] = data;
                end
                1: begin
                    addrs[i] = AHB_BASE | {22'b0, pick[9:2], 2'b00};
                    ahb_exp[pick[9:2]] = data;
                end
                default: begin
                    addrs[i] = timer_addr(pick[0] ? TIMER_MTIMECMPH_OFS : TIMER_MTIMECMP_OFS);
                    cmp_exp[pick[0]] = data;
                end
            endcase
            write_expect(MEM_WIDTH_WORD, addrs[i], data, MEM_RESP_RDY_OK);
        end
        for (int i = 0; i < 9; i++) begin
            case (i % 3)
                0:       expd = tcm_exp[addrs[i][11:2]];
                1:       expd = ahb_exp[addrs[i][9:2]];
                default: expd = cmp_exp[addrs[i][2]];   // Bit 2 picks the high half
            endcase
            read_expect(MEM_WIDTH_WORD, addrs[i], MEM_RESP_RDY_OK, expd);
        end
    endtask

`endif

// ==== test/tb_top.sv ====
//------------------------------------------------
// Testbench for the data memory subsystem. Drives
// the host port and models an AHB-Lite slave
//------------------------------------------------
`timescale 1ns/100ps

module tb_top;

    import scr1_mem_pkg::*;

    localparam logic [31:0] AHB_BASE       = 32'h8000_0000;
    localparam logic [31:0] AHB_ERR_BASE   = 32'hF000_0000;
    localparam int          TIMEOUT_CYCLES = 100;

    logic           clk = 1'b0;
    logic           reset = 1'b1;
    logic           dmem_req = 1'b0;
    mem_req_t       dmem_cmd = '0;
    logic           dmem_req_ack;
    mem_rsp_t       dmem_rsp;
    logic           timer_irq;
    logic [63:0]    mtime;
    logic [1:0]     htrans;
    logic [2:0]     hsize;
    logic [31:0]    haddr;
    logic           hwrite;
    logic [31:0]    hwdata;
    logic           hready = 1'b1;
    logic [31:0]    hrdata = '0;
    logic           hresp = 1'b0;

    `include "tb_tasks.svh"

    always #4 clk = ~clk;   // 8 ns period

    scr1_dmem_subsys_top dut0 (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_dmem_req     (dmem_req),
        .i_dmem_cmd     (dmem_cmd),
        .o_dmem_req_ack (dmem_req_ack),
        .o_dmem_rsp     (dmem_rsp),
        .o_timer_irq    (timer_irq),
        .o_mtime        (mtime),
        .o_htrans       (htrans),
        .o_hsize        (hsize),
        .o_haddr        (haddr),
        .o_hwrite       (hwrite),
        .o_hwdata       (hwdata),
        .i_hready       (hready),
        .i_hrdata       (hrdata),
        .i_hresp        (hresp)
    );

    //------------------------------------------------
    // AHB-Lite slave, 1 KiB of words at AHB_BASE
    //------------------------------------------------
    logic [31:0]    ahb_mem [256];
    logic           dp_active;      // Data phase in progress
    logic           dp_write;
    logic           dp_hit;
    logic [7:0]     dp_idx;
    logic [1:0]     wait_cnt;
    integer         wait_seed = 32'h1eb2_ad1a;

    always @(posedge clk) begin
        logic [1:0] waits;
        if (reset) begin
            hready    <= 1'b1;
            hresp     <= 1'b0;
            dp_active <= 1'b0;
        end else if (dp_active) begin
            if (hready) begin
                if (dp_write && dp_hit) ahb_mem[dp_idx] <= hwdata;
                dp_active <= 1'b0;
                hresp     <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
                hready   <= (wait_cnt == 2'd1);
            end
        end else if (htrans == 2'b10) begin
            // Idle slave keeps hready high, so the address phase is taken now
            check(hsize, 3'b010, "AHB hsize for a word access");
            waits     = 2'($random(wait_seed));
            dp_active <= 1'b1;
            dp_write  <= hwrite;
            dp_hit    <= (haddr[31:10] == AHB_BASE[31:10]);
            dp_idx    <= haddr[9:2];
            wait_cnt  <= waits;
            hready    <= (waits == 2'd0);
            hresp     <= (haddr >= AHB_ERR_BASE);
            hrdata    <= (haddr[31:10] == AHB_BASE[31:10]) ? ahb_mem[haddr[9:2]] : '0;
        end
    end

    //------------------------------------------------
    // Test sequence
    //------------------------------------------------
    initial begin
        for (int i = 0; i < 256; i++) begin
            ahb_mem[i] = ahb_fill(8'(i));
            ahb_exp[i] = ahb_fill(8'(i));
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_tcm_lanes();
        test_ahb_path();
        test_timer_count();
        test_timer_irq();
        test_mixed_traffic();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_top

// ==== flist.f ====
+incdir+test
src/scr1_mem_pkg.sv
src/scr1_dmem_router.sv
src/scr1_tcm.sv
src/scr1_timer.sv
src/scr1_dmem_ahb.sv
src/scr1_dmem_subsys_top.sv
test/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the data memory subsystem testbench

VERILATOR ?= verilator
TOP       := tb_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
